// ==== exec_core.sv ====
// Decode, execute, memory and write-back stages
`timescale 1ns/1ps
`include "tiny_pipe_cfg.svh"

module exec_core (
    input  logic      clk,
    input  logic      rst,
    stage_bus_if.core bus,
    trace_if.core     trace
);
    import tiny_pipe_pkg::*;

    localparam int NREG    = 2 ** $bits(reg_idx_t);
    localparam int DMEM_AW = $clog2(`TP_DMEM_DEPTH);

    // Decode register
    logic                  d_valid;
    logic [`TP_PC_W-1:0]   d_pc;
    instr_t                d_instr;
    // Execute register
    logic                  ex_valid;
    logic [`TP_PC_W-1:0]   ex_pc;
    opcode_e               ex_op;
    reg_idx_t              ex_rd;
    reg_idx_t              ex_rs1;
    reg_idx_t              ex_rs2;
    logic [`TP_DATA_W-1:0] ex_a;
    logic [`TP_DATA_W-1:0] ex_b;
    logic [`TP_DATA_W-1:0] ex_imm;
    // Memory register
    logic                  m_valid;
    logic [`TP_PC_W-1:0]   m_pc;
    opcode_e               m_op;
    reg_idx_t              m_rd;
    logic [`TP_DATA_W-1:0] m_val;
    logic [DMEM_AW-1:0]    m_addr;
    // Write-back register
    logic                  w_valid;
    logic [`TP_PC_W-1:0]   w_pc;
    opcode_e               w_op;
    reg_idx_t              w_rd;
    logic [`TP_DATA_W-1:0] w_result;

    // Architectural state
    logic [`TP_DATA_W-1:0] rf   [NREG];
    logic [`TP_DATA_W-1:0] dmem [`TP_DMEM_DEPTH];

    logic                  ex_wr, m_wr, w_wr;
    reg_idx_t              d_rs2;
    logic [`TP_DATA_W-1:0] rs1_val, rs2_val, ex_result;
    logic                  hazard, stall, flush;

    function automatic logic writes_reg(opcode_e op);
        return op inside {OP_LDI, OP_ADD, OP_SUB, OP_LD};
    endfunction

    function automatic logic reads_rs1(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_LD, OP_ST};
    endfunction

    function automatic logic reads_rs2(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_ST};
    endfunction

    // True when an instruction with these sources reads register r
    function automatic logic reads_reg(opcode_e op, reg_idx_t s1, reg_idx_t s2, reg_idx_t r);
        return (reads_rs1(op) && s1 == r) || (reads_rs2(op) && s2 == r);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Decode and interlock
    //////////////////////////////////////////////////////////////////////

    assign ex_wr = ex_valid && writes_reg(ex_op);
    assign m_wr  = m_valid && writes_reg(m_op);
    assign w_wr  = w_valid && writes_reg(w_op);
    assign d_rs2 = d_instr.imm[7:6];

    // No forwarding, wait until the producer reaches write-back
    assign hazard = d_valid && (
        (reads_rs1(d_instr.op) && ((ex_wr && ex_rd == d_instr.rs1) ||
                                   (m_wr && m_rd == d_instr.rs1))) ||
        (reads_rs2(d_instr.op) && ((ex_wr && ex_rd == d_rs2) ||
                                   (m_wr && m_rd == d_rs2))));

    // Jump in execute wins, the stalled instruction is wrong path anyway
    assign flush = ex_valid && ex_op == OP_JMP;
    assign stall = hazard && !flush;

    // Write-back value is visible to decode in the same cycle
    assign rs1_val = (w_wr && w_rd == d_instr.rs1) ? w_result : rf[d_instr.rs1];
    assign rs2_val = (w_wr && w_rd == d_rs2) ? w_result : rf[d_rs2];

    // Execute ALU, ST carries its store data on
    always_comb begin
        case (ex_op)
            OP_LDI:  ex_result = ex_imm;
            OP_ADD:  ex_result = ex_a + ex_b;
            OP_SUB:  ex_result = ex_a - ex_b;
            OP_ST:   ex_result = ex_b;
            OP_JMP:  ex_result = ex_imm;
            default: ex_result = ex_a;
        endcase
    end

    // Stage valids, a stall leaves a bubble in execute
    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid  <= 1'b0;
            ex_valid <= 1'b0;
            m_valid  <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            if (flush)
                d_valid <= 1'b0;
            else if (!stall)
                d_valid <= bus.f_valid;
            ex_valid <= d_valid && !stall && !flush;
            m_valid  <= ex_valid;
            w_valid  <= m_valid;
        end
    end

    // Stage payloads
    always_ff @(posedge clk) begin
        if (!stall) begin
            d_pc    <= bus.f_pc;
            d_instr <= instr_t'(bus.f_instr);
        end
        ex_pc    <= d_pc;
        ex_op    <= d_instr.op;
        ex_rd    <= d_instr.rd;
        ex_rs1   <= d_instr.rs1;
        ex_rs2   <= d_rs2;
        ex_a     <= rs1_val;
        ex_b     <= rs2_val;
        ex_imm   <= d_instr.imm;
        m_pc     <= ex_pc;
        m_op     <= ex_op;
        m_rd     <= ex_rd;
        m_val    <= ex_result;
        m_addr   <= ex_a[DMEM_AW-1:0];
        w_pc     <= m_pc;
        w_op     <= m_op;
        w_rd     <= m_rd;
        w_result <= (m_op == OP_LD) ? dmem[m_addr] : m_val;
    end

    // Data memory write in the memory stage, register write in write-back
    always_ff @(posedge clk) begin
        if (m_valid && m_op == OP_ST)
            dmem[m_addr] <= m_val;
        if (w_wr)
            rf[w_rd] <= w_result;
    end

    // Control back to fetch
    assign bus.stall       = stall;
    assign bus.flush       = flush;
    assign bus.redirect_pc = ex_imm;

    // Trace strobes follow the same advance rules
    assign trace.take      = bus.f_valid && !stall && !flush;
    assign trace.stall     = stall;
    assign trace.flush     = flush;
    assign trace.wb_valid  = w_valid;
    assign trace.wb_pc     = w_pc;
    assign trace.wb_op     = w_op;
    assign trace.wb_rd     = w_rd;
    assign trace.wb_result = w_result;

    // Stall bubbles keep a consumer out of execute while its producer
    // is still in memory or write-back, otherwise it read a stale value
    a_operands_fresh : assert property (
        @(posedge clk) disable iff (rst)
        ex_valid |-> !(m_wr && reads_reg(ex_op, ex_rs1, ex_rs2, m_rd)) &&
                     !(w_wr && reads_reg(ex_op, ex_rs1, ex_rs2, w_rd))
    );

endmodule

// ==== fetch_unit.sv ====
// Instruction fetch stage
`timescale 1ns/1ps
`include "tiny_pipe_cfg.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`TP_PC_W-1:0]    imem_addr,
    input  logic [`TP_INSTR_W-1:0] imem_data,
    stage_bus_if.fetch             bus
);

    // Address of the word presented on imem_data this cycle
    logic [`TP_PC_W-1:0] pc;

    // Instruction memory answers in the same cycle
    assign imem_addr = pc;

    // PC and fetch register valid
    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= '0;
            bus.f_valid <= 1'b0;
        end else if (bus.flush) begin
            // Jump resolved, word at pc is wrong path and dropped
            pc          <= bus.redirect_pc;
            bus.f_valid <= 1'b0;
        end else if (!bus.stall) begin
            pc          <= pc + 1'b1;
            bus.f_valid <= 1'b1;
        end
    end

    // Fetch register payload, held while decode is stalled
    always_ff @(posedge clk) begin
        if (!bus.stall) begin
            bus.f_pc    <= pc;
            bus.f_instr <= imem_data;
        end
    end

    // Core must drop a hazard stall when it redirects
    a_no_stall_with_flush : assert property (
        @(posedge clk) disable iff (rst) !(bus.stall && bus.flush)
    );

endmodule

// ==== retire_tracker.sv ====
// Instruction sequence and retire tracking
`timescale 1ns/1ps
`include "tiny_pipe_cfg.svh"

module retire_tracker (
    input  logic                    clk,
    input  logic                    rst,
    trace_if.tracker                trace,
    output logic                    retire_valid,
    output logic [`TP_SEQ_W-1:0]    retire_seq,
    output logic [`TP_PC_W-1:0]     retire_pc,
    output tiny_pipe_pkg::opcode_e  retire_op,
    output tiny_pipe_pkg::reg_idx_t retire_rd,
    output logic [`TP_DATA_W-1:0]   retire_result,
    output logic [`TP_STALL_W-1:0]  retire_stalls
);
    import tiny_pipe_pkg::*;

    // Slot index per stage
    localparam int S_F   = 0;
    localparam int S_D   = 1;
    localparam int S_E   = 2;
    localparam int S_M   = 3;
    localparam int S_W   = 4;
    localparam int NSLOT = 5;

    logic [`TP_SEQ_W-1:0]   next_seq;
    logic                   slot_valid  [NSLOT];
    logic [`TP_SEQ_W-1:0]   slot_seq    [NSLOT];
    logic [`TP_STALL_W-1:0] slot_stalls [NSLOT];

    // Last retired number, kept for the ordering check
    logic                   seen;
    logic [`TP_SEQ_W-1:0]   last_seq;

    //////////////////////////////////////////////////////////////////////
    // Slot shifting, mirrors the core on take, stall and flush
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            next_seq <= '0;
            for (int i = 0; i < NSLOT; i++)
                slot_valid[i] <= 1'b0;
        end else begin
            // Fetch register fills on every unstalled edge
            if (trace.flush) begin
                slot_valid[S_F] <= 1'b0;
            end else if (!trace.stall) begin
                slot_valid[S_F] <= 1'b1;
                next_seq        <= next_seq + 1'b1;
            end
            if (trace.flush)
                slot_valid[S_D] <= 1'b0;
            else if (!trace.stall)
                slot_valid[S_D] <= trace.take;
            slot_valid[S_E] <= slot_valid[S_D] && !trace.stall && !trace.flush;
            slot_valid[S_M] <= slot_valid[S_E];
            slot_valid[S_W] <= slot_valid[S_M];
        end
    end

    // Numbers and stall counts
    always_ff @(posedge clk) begin
        if (!trace.stall) begin
            slot_seq[S_F]    <= next_seq;
            slot_stalls[S_F] <= '0;
            slot_seq[S_D]    <= slot_seq[S_F];
            slot_stalls[S_D] <= slot_stalls[S_F];
        end else if (slot_stalls[S_D] != '1) begin
            // Another cycle waiting in decode, saturating
            slot_stalls[S_D] <= slot_stalls[S_D] + 1'b1;
        end
        for (int i = S_E; i < NSLOT; i++) begin
            slot_seq[i]    <= slot_seq[i-1];
            slot_stalls[i] <= slot_stalls[i-1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Retire record, one cycle after write-back
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            seen         <= 1'b0;
        end else begin
            retire_valid <= slot_valid[S_W];
            if (retire_valid)
                seen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        retire_seq    <= slot_seq[S_W];
        retire_stalls <= slot_stalls[S_W];
        retire_pc     <= trace.wb_pc;
        retire_op     <= trace.wb_op;
        retire_rd     <= trace.wb_rd;
        retire_result <= trace.wb_result;
        if (retire_valid)
            last_seq <= retire_seq;
    end

    // Core only takes from a fetch register the tracker also sees as full
    a_take_has_slot : assert property (
        @(posedge clk) disable iff (rst) trace.take |-> slot_valid[S_F]
    );

    // Tracker write-back slot lines up with the core
    a_wb_in_step : assert property (
        @(posedge clk) disable iff (rst) slot_valid[S_W] == trace.wb_valid
    );

    // Retirement in program order
    a_seq_increasing : assert property (
        @(posedge clk) disable iff (rst) retire_valid && seen |-> retire_seq > last_seq
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the tiny pipeline testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_tiny_pipe -f tiny_pipe.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/Vtb_tiny_pipe > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation passed"
exit 0

// ==== stage_bus_if.sv ====
// Fetch to core stage bus
`timescale 1ns/1ps
`include "tiny_pipe_cfg.svh"

interface stage_bus_if;

    // Fetch register contents
    logic                   f_valid;
    logic [`TP_PC_W-1:0]    f_pc;
    logic [`TP_INSTR_W-1:0] f_instr;

    // Pipeline control from the core
    // Stall is a level, flush a single cycle pulse
    logic                   stall;
    logic                   flush;
    // Jump target, loaded into the PC with flush
    logic [`TP_PC_W-1:0]    redirect_pc;

    modport fetch (
        output f_valid, f_pc, f_instr,
        input  stall, flush, redirect_pc
    );

    modport core (
        input  f_valid, f_pc, f_instr,
        output stall, flush, redirect_pc
    );

endinterface

// ==== tb_tiny_pipe.sv ====
// Tiny pipeline testbench
`timescale 1ns/1ps
`include "tiny_pipe_cfg.svh"

module tb_tiny_pipe;
    import tiny_pipe_pkg::*;

    localparam int         TIMEOUT   = 400;
    localparam logic [7:0] MARKER_PC = 8'd22;

    logic                   clk;
    logic                   rst;
    logic [`TP_PC_W-1:0]    imem_addr;
    logic [`TP_INSTR_W-1:0] imem_data;
    logic                   retire_valid;
    logic [`TP_SEQ_W-1:0]   retire_seq;
    logic [`TP_PC_W-1:0]    retire_pc;
    opcode_e                retire_op;
    reg_idx_t               retire_rd;
    logic [`TP_DATA_W-1:0]  retire_result;
    logic [`TP_STALL_W-1:0] retire_stalls;

    // Instruction memory image
    logic [`TP_INSTR_W-1:0] prog [2**`TP_PC_W];

    // Expected retire records in program order
    logic [`TP_SEQ_W-1:0]   exp_seq    [64];
    logic [`TP_PC_W-1:0]    exp_pc     [64];
    opcode_e                exp_op     [64];
    reg_idx_t               exp_rd     [64];
    logic [`TP_DATA_W-1:0]  exp_res    [64];
    logic [`TP_STALL_W-1:0] exp_stalls [64];
    logic [5:0]             n_exp;
    logic [5:0]             ret_idx;

    // Record expected at the next retirement
    logic [`TP_SEQ_W-1:0]   x_seq;
    logic [`TP_PC_W-1:0]    x_pc;
    opcode_e                x_op;
    reg_idx_t               x_rd;
    logic [`TP_DATA_W-1:0]  x_res;
    logic [`TP_STALL_W-1:0] x_stalls;
    logic                   checking;

    tiny_pipe_top u_tiny_pipe_top (
        .clk           (clk),
        .rst           (rst),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .retire_valid  (retire_valid),
        .retire_seq    (retire_seq),
        .retire_pc     (retire_pc),
        .retire_op     (retire_op),
        .retire_rd     (retire_rd),
        .retire_result (retire_result),
        .retire_stalls (retire_stalls)
    );

    // Same cycle instruction memory
    assign imem_data = prog[imem_addr];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Program image
    //////////////////////////////////////////////////////////////////////

    // Register form, rs2 in [7:6]
    function automatic logic [15:0] alu_word(opcode_e op, reg_idx_t rd, reg_idx_t rs1,
                                             reg_idx_t rs2);
        return {op, rd, rs1, rs2, 6'b0};
    endfunction

    // Immediate form, also jump target
    function automatic logic [15:0] imm_word(opcode_e op, reg_idx_t rd, reg_idx_t rs1,
                                             logic [7:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    task automatic load_program();
        // Unused words load r3 with their own address
        for (int i = 0; i < 2**`TP_PC_W; i++)
            prog[i[7:0]] = imm_word(OP_LDI, 2'd3, 2'd0, i[7:0]);
        prog[8'd0]  = imm_word(OP_LDI, 2'd0, 2'd0, 8'h05);
        prog[8'd1]  = imm_word(OP_LDI, 2'd1, 2'd0, 8'h03);
        // Adjacent producer, two stall cycles
        prog[8'd2]  = alu_word(OP_ADD, 2'd2, 2'd0, 2'd1);
        prog[8'd3]  = alu_word(OP_SUB, 2'd3, 2'd2, 2'd0);
        prog[8'd4]  = imm_word(OP_LDI, 2'd1, 2'd0, 8'h0A);
        prog[8'd5]  = imm_word(OP_LDI, 2'd0, 2'd0, 8'h07);
        // Producer two back, one stall and a write-back read
        prog[8'd6]  = alu_word(OP_ADD, 2'd2, 2'd1, 2'd3);
        prog[8'd7]  = imm_word(OP_LDI, 2'd3, 2'd0, 8'h04);
        prog[8'd8]  = alu_word(OP_ST,  2'd0, 2'd3, 2'd2);
        prog[8'd9]  = imm_word(OP_LDI, 2'd0, 2'd0, 8'h21);
        prog[8'd10] = alu_word(OP_LD,  2'd1, 2'd3, 2'd0);
        prog[8'd11] = alu_word(OP_SUB, 2'd2, 2'd1, 2'd0);
        prog[8'd12] = imm_word(OP_JMP, 2'd0, 2'd0, 8'd15);
        // Wrong path, must never retire
        prog[8'd13] = imm_word(OP_LDI, 2'd0, 2'd0, 8'hEE);
        prog[8'd14] = imm_word(OP_LDI, 2'd1, 2'd0, 8'hEE);
        prog[8'd15] = alu_word(OP_ADD, 2'd3, 2'd2, 2'd2);
        prog[8'd16] = imm_word(OP_LDI, 2'd0, 2'd0, 8'h02);
        prog[8'd17] = alu_word(OP_ST,  2'd0, 2'd0, 2'd3);
        prog[8'd18] = alu_word(OP_LD,  2'd2, 2'd0, 2'd0);
        prog[8'd19] = imm_word(OP_JMP, 2'd0, 2'd0, 8'd22);
        prog[8'd20] = imm_word(OP_LDI, 2'd2, 2'd0, 8'hEE);
        prog[8'd21] = imm_word(OP_LDI, 2'd3, 2'd0, 8'hEE);
        // Final marker
        prog[8'd22] = imm_word(OP_LDI, 2'd3, 2'd0, 8'hA5);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model in architectural order
    //////////////////////////////////////////////////////////////////////

    function automatic logic [`TP_STALL_W-1:0] stall_bits(int v);
        return (v > 7) ? '1 : v[`TP_STALL_W-1:0];
    endfunction

    task automatic build_expected();
        logic [`TP_PC_W-1:0]    pc;
        logic [`TP_INSTR_W-1:0] w;
        logic [`TP_SEQ_W-1:0]   seq;
        logic [`TP_DATA_W-1:0]  regs [4];
        logic [`TP_DATA_W-1:0]  dm   [`TP_DMEM_DEPTH];
        logic [`TP_DATA_W-1:0]  a;
        logic [`TP_DATA_W-1:0]  b;
        logic [`TP_DATA_W-1:0]  res;
        int                     ready [4];
        int                     prev_t;
        int                     base;
        int                     t;
        logic                   after_jmp;
        logic                   done;
        opcode_e                op;
        reg_idx_t               rd;
        reg_idx_t               rs1;
        reg_idx_t               rs2;
        logic [5:0]             n;

        pc        = '0;
        seq       = '0;
        prev_t    = -1;
        after_jmp = 1'b0;
        done      = 1'b0;
        n         = '0;
        foreach (ready[i]) ready[i] = -100;
        foreach (regs[i]) regs[i] = '0;
        foreach (dm[i]) dm[i] = '0;
        while (!done && n != 6'd63) begin
            w   = prog[pc];
            op  = opcode_e'(w[15:12]);
            rd  = w[11:10];
            rs1 = w[9:8];
            rs2 = w[7:6];
            a   = regs[rs1];
            b   = regs[rs2];
            // Cycle t is the one where the instruction leaves decode
            // Jump target reaches decode four cycles after the jump
            base = after_jmp ? prev_t + 4 : prev_t + 1;
            t    = base;
            // A source is free once its producer sits in write-back
            if (op inside {OP_ADD, OP_SUB, OP_LD, OP_ST} && ready[rs1] > t)
                t = ready[rs1];
            if (op inside {OP_ADD, OP_SUB, OP_ST} && ready[rs2] > t)
                t = ready[rs2];
            case (op)
                OP_LDI:  res = w[7:0];
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_LD:   res = dm[a[3:0]];
                OP_ST:   res = b;
                OP_JMP:  res = w[7:0];
                default: res = a;
            endcase
            if (op == OP_ST)
                dm[a[3:0]] = b;
            if (op inside {OP_LDI, OP_ADD, OP_SUB, OP_LD}) begin
                regs[rd]  = res;
                ready[rd] = t + 3;
            end
            exp_seq[n]    = seq;
            exp_pc[n]     = pc;
            exp_op[n]     = op;
            exp_rd[n]     = rd;
            exp_res[n]    = res;
            exp_stalls[n] = stall_bits(t - base);
            n             = n + 6'd1;
            prev_t        = t;
            after_jmp     = (op == OP_JMP);
            // Two flushed fetches still used up sequence numbers
            seq = seq + (after_jmp ? 16'd3 : 16'd1);
            if (pc == MARKER_PC)
                done = 1'b1;
            else if (after_jmp)
                pc = w[7:0];
            else
                pc = pc + 8'd1;
        end
        n_exp = n;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(string name, logic [15:0] expected, logic [15:0] actual);
        $display("Mismatch at time %0t: %s expected %0h got %0h", $time, name, expected,
                 actual);
        $display("CHECKS FAILED");
        $fatal(1, "Stopping on first error");
    endtask

    // Count retirements up to the marker
    always @(posedge clk) begin
        if (rst)
            ret_idx <= '0;
        else if (retire_valid && ret_idx < n_exp)
            ret_idx <= ret_idx + 6'd1;
    end

    assign x_seq    = exp_seq[ret_idx];
    assign x_pc     = exp_pc[ret_idx];
    assign x_op     = exp_op[ret_idx];
    assign x_rd     = exp_rd[ret_idx];
    assign x_res    = exp_res[ret_idx];
    assign x_stalls = exp_stalls[ret_idx];
    assign checking = retire_valid && (ret_idx < n_exp);

    a_retire_seq : assert property (@(posedge clk) disable iff (rst)
        checking |-> retire_seq == x_seq)
        else report_mismatch("retire_seq", $sampled(x_seq), $sampled(retire_seq));

    a_retire_pc : assert property (@(posedge clk) disable iff (rst)
        checking |-> retire_pc == x_pc)
        else report_mismatch("retire_pc", {8'd0, $sampled(x_pc)}, {8'd0, $sampled(retire_pc)});

    a_retire_op : assert property (@(posedge clk) disable iff (rst)
        checking |-> retire_op == x_op)
        else report_mismatch("retire_op", {12'd0, $sampled(x_op)},
                             {12'd0, $sampled(retire_op)});

    a_retire_rd : assert property (@(posedge clk) disable iff (rst)
        checking |-> retire_rd == x_rd)
        else report_mismatch("retire_rd", {14'd0, $sampled(x_rd)},
                             {14'd0, $sampled(retire_rd)});

    a_retire_result : assert property (@(posedge clk) disable iff (rst)
        checking |-> retire_result == x_res)
        else report_mismatch("retire_result", {8'd0, $sampled(x_res)},
                             {8'd0, $sampled(retire_result)});

    a_retire_stalls : assert property (@(posedge clk) disable iff (rst)
        checking |-> retire_stalls == x_stalls)
        else report_mismatch("retire_stalls", {13'd0, $sampled(x_stalls)},
                             {13'd0, $sampled(retire_stalls)});

    //////////////////////////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////////////////////////

    initial begin
        int cycles;

        rst <= 1'b1;
        load_program();
        build_expected();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Marker has to retire in bounded time
        cycles = 0;
        while (ret_idx != n_exp && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (ret_idx != n_exp) begin
            $display("Timeout: only %0d of %0d instructions retired", ret_idx, n_exp);
            $display("CHECKS FAILED");
            $fatal(1, "Final instruction never retired");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== tiny_pipe.f ====
+incdir+.
tiny_pipe_pkg.sv
stage_bus_if.sv
trace_if.sv
fetch_unit.sv
exec_core.sv
retire_tracker.sv
tiny_pipe_top.sv
tb_tiny_pipe.sv

// ==== tiny_pipe_cfg.svh ====
// Tiny pipeline configuration
`ifndef TINY_PIPE_CFG_SVH
`define TINY_PIPE_CFG_SVH

// Program counter width, also the instruction memory address width
`define TP_PC_W 8

// Register file and data path width
`define TP_DATA_W 8

// One instruction word
`define TP_INSTR_W 16

// Retire tracker sequence numbers
`define TP_SEQ_W 16

// Decode stall counter, saturates at all ones
`define TP_STALL_W 3

// Words in the core data memory
`define TP_DMEM_DEPTH 16

`endif

// ==== tiny_pipe_pkg.sv ====
// Tiny pipeline shared types
package tiny_pipe_pkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction word layout
    //   [15:12] opcode
    //   [11:10] rd
    //   [9:8]   rs1
    //   [7:6]   rs2 for ADD, SUB and ST
    //   [7:0]   immediate for LDI, jump target for JMP
    // LD reads dmem[rs1], ST writes rs2 into dmem[rs1]
    // Data memory address is the low bits of the rs1 value
    //////////////////////////////////////////////////////////////////////

    // Opcodes, unlisted codes behave as NOP
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_LDI = 4'd1,
        OP_ADD = 4'd2,
        OP_SUB = 4'd3,
        OP_LD  = 4'd4,
        OP_ST  = 4'd5,
        OP_JMP = 4'd6
    } opcode_e;

    // One of four architectural registers
    typedef logic [1:0] reg_idx_t;

    // Decoded view of one instruction word, rs2 lives in imm[7:6]
    typedef struct packed {
        opcode_e    op;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        logic [7:0] imm;
    } instr_t;

endpackage

// ==== tiny_pipe_top.sv ====
// Tiny pipeline top level
`timescale 1ns/1ps
`include "tiny_pipe_cfg.svh"

module tiny_pipe_top (
    input  logic                    clk,
    input  logic                    rst,
    // Instruction memory, read in the same cycle
    output logic [`TP_PC_W-1:0]     imem_addr,
    input  logic [`TP_INSTR_W-1:0]  imem_data,
    // Retire record
    output logic                    retire_valid,
    output logic [`TP_SEQ_W-1:0]    retire_seq,
    output logic [`TP_PC_W-1:0]     retire_pc,
    output tiny_pipe_pkg::opcode_e  retire_op,
    output tiny_pipe_pkg::reg_idx_t retire_rd,
    output logic [`TP_DATA_W-1:0]   retire_result,
    output logic [`TP_STALL_W-1:0]  retire_stalls
);

    // Fetch to core
    stage_bus_if stage_bus ();
    // Core to tracker
    trace_if     trace ();

    fetch_unit u_fetch (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .bus       (stage_bus)
    );

    exec_core u_core (
        .clk   (clk),
        .rst   (rst),
        .bus   (stage_bus),
        .trace (trace)
    );

    retire_tracker u_tracker (
        .clk           (clk),
        .rst           (rst),
        .trace         (trace),
        .retire_valid  (retire_valid),
        .retire_seq    (retire_seq),
        .retire_pc     (retire_pc),
        .retire_op     (retire_op),
        .retire_rd     (retire_rd),
        .retire_result (retire_result),
        .retire_stalls (retire_stalls)
    );

endmodule

// ==== trace_if.sv ====
// Core to retire tracker trace bus
`timescale 1ns/1ps
`include "tiny_pipe_cfg.svh"

interface trace_if;
    import tiny_pipe_pkg::*;

    // Stage advance strobes
    logic                  take;
    logic                  stall;
    logic                  flush;

    // Instruction now in write-back
    logic                  wb_valid;
    logic [`TP_PC_W-1:0]   wb_pc;
    opcode_e               wb_op;
    reg_idx_t              wb_rd;
    logic [`TP_DATA_W-1:0] wb_result;

    modport core (output take, stall, flush, wb_valid, wb_pc, wb_op, wb_rd, wb_result);

    modport tracker (input take, stall, flush, wb_valid, wb_pc, wb_op, wb_rd, wb_result);

endinterface
